/* compile.f */
+incdir+rtl
rtl/sdr_pkg.sv
rtl/sdr_bit_scanner.sv
rtl/sdr_index_fifos.sv
rtl/sdr_index_collector.sv
rtl/sdr_ones_counter.sv
rtl/sdr_to_index_top.sv
verif/tb_clk_gen.sv
verif/sdr_to_index_sva.sv
verif/sdr_to_index_tb.sv

/* Makefile */
TOP := sdr_to_index_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP) -Mdir obj_dir

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

/* verif/sdr_to_index_tb.sv */
// testbench: stimulus, reference model, result checker and watchdog
`timescale 1ns/1ps
`default_nettype none

`include "sdr_config.svh"

module sdr_to_index_tb
	import sdr_pkg::*;
();

	localparam int NUM_TESTS   = 7;
	localparam int CLK_PERIOD  = 20;
	localparam int TIMEOUT_NS  = (NUM_TESTS * (`SDR_WIDTH + 1100) + 50) * CLK_PERIOD;
	localparam int ENTRY_SPACE = 1 << (`SDR_ROW_W + `SDR_COL_W);
	localparam int DENSE_ROW   = 9;

	logic        clk;
	logic        rst_n;
	logic        start;
	logic        busy;
	sdr_matrix_t sdr;
	index_list_t index_list;
	sdr_status_t status;
	sdr_matrix_t exp_matrix;
	int          errors = 0;
	int          checks_done = 0;

	tb_clk_gen i_clk_gen (
		.clk_o  (clk),
		.rst_no (rst_n)
	);

	sdr_to_index_top i_dut (
		.clk_i        (clk),
		.rst_ni       (rst_n),
		.start_i      (start),
		.sdr_i        (sdr),
		.index_list_o (index_list),
		.status_o     (status),
		.busy_o       (busy)
	);

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0d ns: %s", $time, msg);
		errors++;
	endtask

	// entry value is {row, col}, so the set is indexed by it directly
	function automatic void ref_indexes(
		input  sdr_matrix_t            m,
		output logic [ENTRY_SPACE-1:0] exp_set,
		output int                     exp_count,
		output logic                   exp_ovf
	);
		exp_set   = '0;
		exp_count = 0;
		for (int r = 0; r < `SDR_ROWS; r++) begin
			for (int c = 0; c < `SDR_WIDTH; c++) begin
				if (m[r][c]) begin
					exp_set[(r << `SDR_COL_W) | c] = 1'b1;
					exp_count++;
				end
			end
		end
		exp_ovf = (exp_count > `SDR_MAX_INDEXES);
	endfunction

	task automatic check_idle_status(input logic exp_busy, input string phase);
		if (busy !== exp_busy) begin
			report_mismatch($sformatf("%s: busy_o is %b, expected %b", phase, busy, exp_busy));
		end
		if (status.done !== 1'b0 || status.overflow !== 1'b0) begin
			report_mismatch($sformatf("%s: done/overflow not cleared", phase));
		end
		if (status.num_indexes !== '0 || status.num_ones !== '0) begin
			report_mismatch($sformatf("%s: counts are not zero", phase));
		end
		for (int i = 0; i < `SDR_MAX_INDEXES; i++) begin
			if (index_list[i] !== '1) begin
				report_mismatch($sformatf("%s: slot %0d is %h", phase, i, index_list[i]));
			end
		end
	endtask

	task automatic compare_result();
		logic [ENTRY_SPACE-1:0] exp_set;
		logic [ENTRY_SPACE-1:0] seen;
		int                     exp_count;
		logic                   exp_ovf;
		int                     written;
		index_t                 e;
		ref_indexes(exp_matrix, exp_set, exp_count, exp_ovf);
		seen    = '0;
		written = (exp_count < `SDR_MAX_INDEXES) ? exp_count : `SDR_MAX_INDEXES;
		if (int'(status.num_indexes) != exp_count) begin
			report_mismatch($sformatf("num_indexes %0d, expected %0d",
				status.num_indexes, exp_count));
		end
		if (int'(status.num_ones) != exp_count) begin
			report_mismatch($sformatf("num_ones %0d, expected %0d", status.num_ones, exp_count));
		end
		if (status.overflow !== exp_ovf) begin
			report_mismatch($sformatf("overflow %b, expected %b", status.overflow, exp_ovf));
		end
		if (busy !== 1'b0) begin
			report_mismatch("busy_o still high with done");
		end
		for (int i = 0; i < `SDR_MAX_INDEXES; i++) begin
			e = index_list[i];
			if (i >= written) begin
				if (e !== '1) begin
					report_mismatch($sformatf("unused slot %0d holds %h", i, e));
				end
			end else if (e[15:10] != '0 || !exp_set[e[9:0]]) begin
				report_mismatch($sformatf("slot %0d holds unexpected entry %h", i, e));
			end else if (seen[e[9:0]]) begin
				report_mismatch($sformatf("slot %0d repeats entry %h", i, e));
			end else begin
				seen[e[9:0]] = 1'b1;
			end
		end
	endtask

	function automatic sdr_matrix_t random_sparse();
		sdr_matrix_t m;
		int          n;
		m = '0;
		n = $urandom_range(`SDR_MAX_INDEXES, 1);
		// collisions only lower the count
		for (int i = 0; i < n; i++) begin
			m[$urandom_range(`SDR_ROWS - 1, 0)][$urandom_range(`SDR_WIDTH - 1, 0)] = 1'b1;
		end
		return m;
	endfunction

	function automatic sdr_matrix_t random_dense();
		sdr_matrix_t m;
		for (int r = 0; r < `SDR_ROWS; r++) begin
			m[r] = $urandom();
		end
		// a full row above busy lower rows fills its fifo
		m[DENSE_ROW] = '1;
		return m;
	endfunction

	task automatic run_conversion(
		input sdr_matrix_t m,
		input logic        poke_busy,
		input sdr_matrix_t other
	);
		int target;
		target     = checks_done + 1;
		exp_matrix = m;
		@(posedge clk);
		#2;
		sdr   = m;
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		@(negedge clk);
		check_idle_status(1'b1, "after start");
		if (poke_busy) begin
			repeat (5) @(posedge clk);
			#2;
			if (busy !== 1'b1) begin
				report_mismatch("busy_o low during conversion");
			end
			sdr   = other;
			start = 1'b1;
			@(posedge clk);
			#2;
			start = 1'b0;
		end
		wait (checks_done == target);
	endtask

	// compares once per rising done
	initial begin : result_checker
		forever begin
			@(posedge status.done);
			@(negedge clk);
			compare_result();
			checks_done++;
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("timeout: conversions did not finish within %0d ns", TIMEOUT_NS);
		$display("Simulation FAILED");
		$finish;
	end

	initial begin : stimulus
		sdr_matrix_t m;
		int          sva_errors;
		start = 1'b0;
		sdr   = '0;
		void'($urandom(42724));
		wait (rst_n);
		@(negedge clk);
		check_idle_status(1'b0, "after reset");
		repeat (3) begin
			m = random_sparse();
			run_conversion(m, 1'b0, '0);
		end
		run_conversion('0, 1'b0, '0);
		m = random_dense();
		run_conversion(m, 1'b0, '0);
		// start during busy ignored, then a start right after done
		m = random_sparse();
		run_conversion(m, 1'b1, random_dense());
		m = random_sparse();
		run_conversion(m, 1'b0, '0);
		repeat (4) @(posedge clk);
		sva_errors = i_dut.i_collector.i_collector_sva.fail_count;
		errors += sva_errors;
		$display("checks done: %0d, errors: %0d, assertion failures: %0d",
			checks_done, errors, sva_errors);
		if (errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verif/sdr_to_index_sva.sv */
// concurrent assertions on the index collector pops and done flag, with their bind
`timescale 1ns/1ps
`default_nettype none

module sdr_to_index_sva
	import sdr_pkg::*;
(
	input logic      clk_i,
	input logic      rst_ni,
	input row_mask_t rvalid_mask_i,
	input row_mask_t pop_mask_i,
	input logic      done_i
);

	int fail_count = 0;

	// at most one row popped per cycle
	pop_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
		$onehot0(pop_mask_i))
		else begin
			$error("pop mask is neither one-hot nor zero");
			fail_count++;
		end

	// pops only on rows that hold data
	pop_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(pop_mask_i & ~rvalid_mask_i) == '0)
		else begin
			$error("pop on a row without valid data");
			fail_count++;
		end

	pop_after_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
		!(done_i && (|pop_mask_i)))
		else begin
			$error("pop while done is high");
			fail_count++;
		end

endmodule

bind sdr_index_collector sdr_to_index_sva i_collector_sva (
	.clk_i         (clk_i),
	.rst_ni        (rst_ni),
	.rvalid_mask_i (rvalid_mask_i),
	.pop_mask_i    (pop_mask_o),
	.done_i        (done_o)
);

`default_nettype wire

/* verif/tb_clk_gen.sv */
// testbench clock and reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic rst_no
);

	// 20 ns period
	initial begin
		clk_o = 1'b0;
		forever #10 clk_o = ~clk_o;
	end

	// reset held for 10 cycles
	initial begin
		rst_no = 1'b0;
		repeat (10) @(posedge clk_o);
		#2 rst_no = 1'b1;
	end

endmodule

`default_nettype wire

/* rtl/sdr_to_index_top.sv */
// top level: scanner, row fifos, index collector and ones counter
`timescale 1ns/1ps
`default_nettype none

module sdr_to_index_top
	import sdr_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_ni,
	input  logic        start_i,
	input  sdr_matrix_t sdr_i,
	output index_list_t index_list_o,
	output sdr_status_t status_o,
	output logic        busy_o
);

	fifo_push_t  push;
	row_mask_t   full_mask;
	row_mask_t   rvalid_mask;
	row_mask_t   pop_mask;
	col_array_t  rdata;
	sdr_matrix_t matrix;
	logic        clear;
	logic        scan_done;
	logic        done;
	logic        overflow;
	count_t      num_indexes;
	count_t      num_ones;

	sdr_bit_scanner i_scanner (
		.clk_i          (clk_i),
		.rst_ni         (rst_ni),
		.start_i        (start_i),
		.sdr_i          (sdr_i),
		.collect_done_i (done),
		.full_mask_i    (full_mask),
		.push_o         (push),
		.clear_o        (clear),
		.scan_done_o    (scan_done),
		.matrix_o       (matrix),
		.busy_o         (busy_o)
	);

	sdr_index_fifos i_fifos (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.clr_i         (clear),
		.push_i        (push),
		.pop_mask_i    (pop_mask),
		.full_mask_o   (full_mask),
		.rvalid_mask_o (rvalid_mask),
		.rdata_o       (rdata)
	);

	sdr_index_collector i_collector (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.clr_i         (clear),
		.rvalid_mask_i (rvalid_mask),
		.rdata_i       (rdata),
		.scan_done_i   (scan_done),
		.pop_mask_o    (pop_mask),
		.done_o        (done),
		.overflow_o    (overflow),
		.num_indexes_o (num_indexes),
		.index_list_o  (index_list_o)
	);

	sdr_ones_counter i_ones (
		.clk_i      (clk_i),
		.rst_ni     (rst_ni),
		.clr_i      (clear),
		.matrix_i   (matrix),
		.num_ones_o (num_ones)
	);

	assign status_o.done        = done;
	assign status_o.overflow    = overflow;
	assign status_o.num_indexes = num_indexes;
	assign status_o.num_ones    = num_ones;

endmodule

`default_nettype wire

/* rtl/sdr_ones_counter.sv */
// registered population count of the latched matrix
`timescale 1ns/1ps
`default_nettype none

`include "sdr_config.svh"

module sdr_ones_counter
	import sdr_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_ni,
	input  logic        clr_i,
	input  sdr_matrix_t matrix_i,
	output count_t      num_ones_o
);

	localparam int ROW_CNT_W = $clog2(`SDR_WIDTH + 1);

	logic [ROW_CNT_W-1:0] row_ones [`SDR_ROWS];
	count_t               total;
	count_t               num_ones_q;
	logic                 load_q;

	// per-row counts
	for (genvar r = 0; r < `SDR_ROWS; r++) begin : g_row
		assign row_ones[r] = ROW_CNT_W'($countones(matrix_i[r]));
	end

	always_comb begin
		total = '0;
		for (int r = 0; r < `SDR_ROWS; r++) begin
			total = total + count_t'(row_ones[r]);
		end
	end

	// matrix is latched on the clear edge, so load one cycle later
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			load_q     <= 1'b0;
			num_ones_q <= '0;
		end else begin
			load_q <= clr_i;
			if (clr_i) begin
				num_ones_q <= '0;
			end else if (load_q) begin
				num_ones_q <= total;
			end
		end
	end

	assign num_ones_o = num_ones_q;

endmodule

`default_nettype wire

/* rtl/sdr_index_collector.sv */
// index collector: priority pop, index list, counter and done/overflow
`timescale 1ns/1ps
`default_nettype none

`include "sdr_config.svh"

module sdr_index_collector
	import sdr_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_ni,
	input  logic        clr_i,
	input  row_mask_t   rvalid_mask_i,
	input  col_array_t  rdata_i,
	input  logic        scan_done_i,
	output row_mask_t   pop_mask_o,
	output logic        done_o,
	output logic        overflow_o,
	output count_t      num_indexes_o,
	output index_list_t index_list_o
);

	localparam int SLOT_W = $clog2(`SDR_MAX_INDEXES);
	localparam count_t MAX_SLOTS = count_t'(`SDR_MAX_INDEXES);

	row_idx_t    sel_row;
	logic        any_valid;
	index_t      entry;
	count_t      idx_cnt_q;
	logic        done_q;
	logic        overflow_q;
	index_list_t list_q;
	logic        slot_free;

	// lowest valid row wins
	always_comb begin
		sel_row   = '0;
		any_valid = 1'b0;
		for (int r = `SDR_ROWS - 1; r >= 0; r--) begin
			if (rvalid_mask_i[r]) begin
				sel_row   = row_idx_t'(r);
				any_valid = 1'b1;
			end
		end
	end

	assign pop_mask_o = any_valid ? (row_mask_t'(1) << sel_row) : '0;

	// row in [9:5], column in [4:0]
	assign entry = index_t'({sel_row, rdata_i[sel_row]});

	assign slot_free = (idx_cnt_q < MAX_SLOTS);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			idx_cnt_q  <= '0;
			overflow_q <= 1'b0;
			done_q     <= 1'b0;
		end else if (clr_i) begin
			idx_cnt_q  <= '0;
			overflow_q <= 1'b0;
			done_q     <= 1'b0;
		end else begin
			if (any_valid) begin
				idx_cnt_q <= idx_cnt_q + 1'b1;
				if (!slot_free) begin
					overflow_q <= 1'b1;
				end
			end
			// scan finished and nothing left in any fifo
			if (scan_done_i && !any_valid) begin
				done_q <= 1'b1;
			end
		end
	end

	// unused slots read as all ones
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			list_q <= '1;
		end else if (clr_i) begin
			list_q <= '1;
		end else if (any_valid && slot_free) begin
			list_q[idx_cnt_q[SLOT_W-1:0]] <= entry;
		end
	end

	assign done_o        = done_q;
	assign overflow_o    = overflow_q;
	assign num_indexes_o = idx_cnt_q;
	assign index_list_o  = list_q;

endmodule

`default_nettype wire

/* rtl/sdr_index_fifos.sv */
// bank of per-row synchronous fifos holding column numbers
`timescale 1ns/1ps
`default_nettype none

`include "sdr_config.svh"

module sdr_index_fifos
	import sdr_pkg::*;
(
	input  logic       clk_i,
	input  logic       rst_ni,
	input  logic       clr_i,
	input  fifo_push_t push_i,
	input  row_mask_t  pop_mask_i,
	output row_mask_t  full_mask_o,
	output row_mask_t  rvalid_mask_o,
	output col_array_t rdata_o
);

	localparam int PTR_W = $clog2(`SDR_FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	localparam logic [CNT_W-1:0] DEPTH = CNT_W'(`SDR_FIFO_DEPTH);

	for (genvar r = 0; r < `SDR_ROWS; r++) begin : g_row
		col_t             mem_q [`SDR_FIFO_DEPTH];
		logic [PTR_W-1:0] wptr_q;
		logic [PTR_W-1:0] rptr_q;
		logic [CNT_W-1:0] cnt_q;
		logic             full;
		logic             valid;
		logic             wr_en;
		logic             rd_en;

		assign full  = (cnt_q == DEPTH);
		assign valid = (cnt_q != '0);

		// a full fifo drops nothing since the scanner stalls first
		assign wr_en = push_i.mask[r] && !full;
		assign rd_en = pop_mask_i[r] && valid;

		assign full_mask_o[r]   = full;
		assign rvalid_mask_o[r] = valid;
		assign rdata_o[r]       = mem_q[rptr_q];

		always_ff @(posedge clk_i or negedge rst_ni) begin
			if (!rst_ni) begin
				wptr_q <= '0;
				rptr_q <= '0;
				cnt_q  <= '0;
			end else if (clr_i) begin
				wptr_q <= '0;
				rptr_q <= '0;
				cnt_q  <= '0;
			end else begin
				if (wr_en) begin
					wptr_q <= wptr_q + 1'b1;
				end
				if (rd_en) begin
					rptr_q <= rptr_q + 1'b1;
				end
				// simultaneous push and pop leaves the count unchanged
				if (wr_en && !rd_en) begin
					cnt_q <= cnt_q + 1'b1;
				end else if (rd_en && !wr_en) begin
					cnt_q <= cnt_q - 1'b1;
				end
			end
		end

		always_ff @(posedge clk_i) begin
			if (wr_en) begin
				mem_q[wptr_q] <= push_i.col;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/sdr_bit_scanner.sv */
// bit scanner: latches the matrix and pushes column numbers per row
`timescale 1ns/1ps
`default_nettype none

`include "sdr_config.svh"

module sdr_bit_scanner
	import sdr_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_ni,
	input  logic        start_i,
	input  sdr_matrix_t sdr_i,
	input  logic        collect_done_i,
	input  row_mask_t   full_mask_i,
	output fifo_push_t  push_o,
	output logic        clear_o,
	output logic        scan_done_o,
	output sdr_matrix_t matrix_o,
	output logic        busy_o
);

	localparam col_t LAST_COL = col_t'(`SDR_WIDTH - 1);

	scan_state_e state_q, state_d;
	col_t        col_q, col_d;
	sdr_matrix_t matrix_q;
	row_mask_t   want;
	logic        stall;
	logic        ready;

	// bit col_q of every row
	always_comb begin
		for (int r = 0; r < `SDR_ROWS; r++) begin
			want[r] = matrix_q[r][col_q];
		end
	end

	// hold the column until every wanted fifo has room
	assign stall = |(want & full_mask_i);

	// idle, or about to go idle because the collector is done
	assign ready = (state_q == SCAN_IDLE) || ((state_q == SCAN_DRAIN) && collect_done_i);

	assign clear_o     = start_i && ready;
	assign busy_o      = !ready;
	assign scan_done_o = (state_q == SCAN_DRAIN);
	assign matrix_o    = matrix_q;

	assign push_o.mask = ((state_q == SCAN_RUN) && !stall) ? want : '0;
	assign push_o.col  = col_q;

	always_comb begin
		state_d = state_q;
		col_d   = col_q;
		case (state_q)
			SCAN_RUN: begin
				if (!stall) begin
					if (col_q == LAST_COL) begin
						state_d = SCAN_DRAIN;
					end else begin
						col_d = col_q + 1'b1;
					end
				end
			end
			SCAN_DRAIN: begin
				if (collect_done_i) begin
					state_d = SCAN_IDLE;
				end
			end
			default: state_d = SCAN_IDLE;
		endcase
		// an accepted start always restarts at column 0
		if (clear_o) begin
			state_d = SCAN_RUN;
			col_d   = '0;
		end
	end

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= SCAN_IDLE;
			col_q   <= '0;
		end else begin
			state_q <= state_d;
			col_q   <= col_d;
		end
	end

	always_ff @(posedge clk_i) begin
		if (clear_o) begin
			matrix_q <= sdr_i;
		end
	end

endmodule

`default_nettype wire

/* rtl/sdr_pkg.sv */
// vector typedefs, push and status structs and scanner state enum
`default_nettype none

`include "sdr_config.svh"

package sdr_pkg;

	typedef logic [`SDR_WIDTH-1:0] sdr_row_t;
	typedef sdr_row_t [`SDR_ROWS-1:0] sdr_matrix_t;

	typedef logic [`SDR_COL_W-1:0] col_t;
	typedef logic [`SDR_ROW_W-1:0] row_idx_t;

	// {zeros, row[9:5], col[4:0]}, all ones when unused
	typedef logic [`SDR_INDEX_W-1:0] index_t;
	typedef logic [`SDR_COUNT_W-1:0] count_t;

	// one bit per row
	typedef logic [`SDR_ROWS-1:0] row_mask_t;
	typedef col_t [`SDR_ROWS-1:0] col_array_t;
	typedef index_t [`SDR_MAX_INDEXES-1:0] index_list_t;

	// one column shared by every row selected in the mask
	typedef struct packed {
		row_mask_t mask;
		col_t      col;
	} fifo_push_t;

	typedef struct packed {
		logic   done;
		logic   overflow;
		count_t num_indexes;
		count_t num_ones;
	} sdr_status_t;

	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_RUN,
		SCAN_DRAIN
	} scan_state_e;

endpackage

`default_nettype wire

/* rtl/sdr_config.svh */
// matrix geometry, row fifo depth and index list length
`ifndef SDR_CONFIG_SVH
`define SDR_CONFIG_SVH

// matrix geometry
`define SDR_ROWS 32
`define SDR_WIDTH 32
`define SDR_COL_W 5
`define SDR_ROW_W 5

// entries per row fifo
`define SDR_FIFO_DEPTH 8

// index list, packed two entries per 32-bit word
`define SDR_MAX_INDEXES 32
`define SDR_INDEX_W 16

// wide enough for a fully set 32x32 matrix
`define SDR_COUNT_W 11

`endif
